// ==== hdl/prefix_pkg.sv ====
// Operand width constant and prefix level helpers for the Ling adder
package prefix_pkg;

	localparam int DEFAULT_WIDTH = 26;

	// Levels needed before the top H bit covers bit 0
	function automatic int prefix_levels(input int width);
		int levels;
		levels = 0;
		while ((1 << levels) < width) begin
			levels++;
		end
		return levels;
	endfunction

	// Span doubles at every level
	function automatic int level_span(input int level);
		return 1 << level;
	endfunction

	function automatic bit is_pow2(input int value);
		return value > 0 && (value & (value - 1)) == 0;
	endfunction

endpackage

// ==== hdl/handshake_pkg.sv ====
// Slot state enumeration and link phase decoding for four-phase handshakes
package handshake_pkg;

	typedef enum logic [1:0] {
		EMPTY,
		OFFER,
		RETIRE
	} slot_state_t;

	// Sender state implied by the req/ack pair on a link
	function automatic slot_state_t sender_state(input logic req, input logic ack);
		if (req) begin
			return OFFER;
		end
		if (ack) begin
			return RETIRE;
		end
		return EMPTY;
	endfunction

endpackage

// ==== hdl/stage_link_if.sv ====
// Four-phase stage link with typed payload, modports and protocol checks
interface stage_link_if #(
	parameter type PAYLOAD_T = logic [7:0]
) (
	input logic clk,
	input logic reset
);
	import handshake_pkg::*;

	logic req;
	logic ack;
	PAYLOAD_T data;

	slot_state_t sender_view;

	assign sender_view = sender_state(req, ack);

	modport sender (output req, output data, input ack);
	modport receiver (input req, input data, output ack);

	data_stable: assert property (@(posedge clk) disable iff (reset)
		(req && $past(req)) |-> $stable(data));

	ack_needs_req: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> sender_view == OFFER);

	// Sender only lets go once it has seen the ack
	req_held: assert property (@(posedge clk) disable iff (reset)
		$fell(req) |-> $past(ack));

	req_after_return: assert property (@(posedge clk) disable iff (reset)
		$rose(req) |-> $past(sender_view) == EMPTY);

endinterface

// ==== hdl/hs_slot.sv ====
// One-item slot controller running four-phase handshakes on both sides
module hs_slot (
	input logic clk,
	input logic reset,
	input logic up_req,
	output logic up_ack,
	output logic dn_req,
	input logic dn_ack,
	output logic load
);
	import handshake_pkg::*;

	slot_state_t state;

	// Fresh request into an empty slot only
	assign load = state == EMPTY && up_req && !up_ack;
	assign dn_req = state == OFFER;

	always_ff @(posedge clk) begin
		if (reset) begin
			up_ack <= 1'b0;
		end else if (load) begin
			up_ack <= 1'b1;
		end else if (!up_req) begin
			up_ack <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= EMPTY;
		end else begin
			case (state)
				EMPTY: begin
					if (load) begin
						state <= OFFER;
					end
				end
				OFFER: begin
					if (dn_ack) begin
						state <= RETIRE;
					end
				end
				RETIRE: begin
					// Downstream ack must return to zero first
					if (!dn_ack) begin
						state <= EMPTY;
					end
				end
				default: begin
					state <= EMPTY;
				end
			endcase
		end
	end

	// An item lands only while the downstream link is idle
	load_in_empty: assert property (@(posedge clk) disable iff (reset)
		load |-> sender_state(dn_req, dn_ack) == EMPTY);

endmodule

// ==== hdl/ling_precompute.sv ====
// Pre-computation stage forming Ling propagate and generate with cin at bit 0
module ling_precompute #(
	parameter int WIDTH = prefix_pkg::DEFAULT_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic [WIDTH-1:0] a,
	input logic [WIDTH-1:0] b,
	input logic cin,
	input logic in_req,
	output logic in_ack,
	stage_link_if.sender out
);

	logic load;
	logic [WIDTH:0] p_q;
	logic [WIDTH:0] g_q;

	hs_slot slot_i (
		.clk(clk),
		.reset(reset),
		.up_req(in_req),
		.up_ack(in_ack),
		.dn_req(out.req),
		.dn_ack(out.ack),
		.load(load)
	);

	// Bit 0 carries cin, so p there is always one
	always_ff @(posedge clk) begin
		if (load) begin
			p_q <= {a | b, 1'b1};
			g_q <= {a & b, cin};
		end
	end

	// Seed the running H and I so every level sees the same word layout
	assign out.data = '{p: p_q, g: g_q, h: g_q, i: p_q};

endmodule

// ==== hdl/knowles_level.sv ====
// One Knowles prefix level of reduced, black and grey cells, registered
module knowles_level #(
	parameter int WIDTH = prefix_pkg::DEFAULT_WIDTH,
	parameter int SPAN = 1
) (
	input logic clk,
	input logic reset,
	stage_link_if.receiver up,
	stage_link_if.sender dn
);
	import prefix_pkg::*;

	localparam bit SPAN_OK = is_pow2(SPAN) && SPAN < WIDTH + 1 &&
		$clog2(SPAN) < prefix_levels(WIDTH);

	logic load;
	logic [WIDTH:0] h_in;
	logic [WIDTH:0] i_in;
	logic [WIDTH:0] h_nx;
	logic [WIDTH:0] i_nx;
	logic [WIDTH:0] p_q;
	logic [WIDTH:0] g_q;
	logic [WIDTH:0] h_q;
	logic [WIDTH:0] i_q;

	hs_slot slot_i (
		.clk(clk),
		.reset(reset),
		.up_req(up.req),
		.up_ack(up.ack),
		.dn_req(dn.req),
		.dn_ack(dn.ack),
		.load(load)
	);

	assign h_in = up.data.h;
	assign i_in = up.data.i;

	for (genvar k = 0; k <= WIDTH; k++) begin : g_pos
		if (k < SPAN) begin : g_pass
			assign h_nx[k] = h_in[k];
			assign i_nx[k] = i_in[k];
		end else if (SPAN == 1) begin : g_reduced
			// Ling form, the propagate pair sits one bit lower
			assign h_nx[k] = h_in[k] | h_in[k-1];
			if (k >= 2) begin : g_rblk
				assign i_nx[k] = i_in[k-1] & i_in[k-2];
			end else begin : g_rgry
				assign i_nx[k] = i_in[k];
			end
		end else if (k < 2 * SPAN) begin : g_grey
			// Lower group already reaches bit 0
			assign h_nx[k] = h_in[k] | (i_in[k] & h_in[k-SPAN]);
			assign i_nx[k] = i_in[k];
		end else begin : g_black
			assign h_nx[k] = h_in[k] | (i_in[k] & h_in[k-SPAN]);
			assign i_nx[k] = i_in[k] & i_in[k-SPAN];
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			p_q <= up.data.p;
			g_q <= up.data.g;
			h_q <= h_nx;
			i_q <= i_nx;
		end
	end

	assign dn.data = '{p: p_q, g: g_q, h: h_q, i: i_q};

	span_legal: assert property (@(posedge clk) disable iff (reset) SPAN_OK);

endmodule

// ==== hdl/ling_postcompute.sv ====
// Post-computation stage turning the H vector into carries, sum and cout
module ling_postcompute #(
	parameter int WIDTH = prefix_pkg::DEFAULT_WIDTH
) (
	input logic clk,
	input logic reset,
	stage_link_if.receiver up,
	stage_link_if.sender res
);

	logic load;
	logic [WIDTH:0] p;
	logic [WIDTH:0] g;
	logic [WIDTH:1] h;
	logic [WIDTH:1] c;
	logic [WIDTH-1:0] sum_q;
	logic cout_q;

	hs_slot slot_i (
		.clk(clk),
		.reset(reset),
		.up_req(up.req),
		.up_ack(up.ack),
		.dn_req(res.req),
		.dn_ack(res.ack),
		.load(load)
	);

	assign p = up.data.p;
	assign g = up.data.g;

	assign c[1] = g[0];

	for (genvar k = 1; k < WIDTH; k++) begin : g_bit
		assign h[k] = up.data.h[k];
		assign c[k+1] = p[k] & up.data.h[k];
	end

	// Top H comes from the carry, not the tree
	assign h[WIDTH] = g[WIDTH] | c[WIDTH];

	always_ff @(posedge clk) begin
		if (load) begin
			sum_q <= (p[WIDTH:1] ^ h) | (g[WIDTH:1] & c);
			cout_q <= p[WIDTH] & h[WIDTH];
		end
	end

	assign res.data = '{sum: sum_q, cout: cout_q};

endmodule

// ==== hdl/knowles_adder_top.sv ====
// Pipelined Ling Knowles adder top with four-phase operand and result ports
module knowles_adder_top #(
	parameter int WIDTH = prefix_pkg::DEFAULT_WIDTH
) (
	input logic clk,
	input logic reset,
	input logic [WIDTH-1:0] a,
	input logic [WIDTH-1:0] b,
	input logic cin,
	input logic in_req,
	output logic in_ack,
	output logic [WIDTH-1:0] sum,
	output logic cout,
	output logic out_req,
	input logic out_ack
);
	import prefix_pkg::*;

	localparam int LEVELS = prefix_levels(WIDTH);

	typedef struct packed {
		logic [WIDTH:0] p;
		logic [WIDTH:0] g;
		logic [WIDTH:0] h;
		logic [WIDTH:0] i;
	} prefix_word_t;

	typedef struct packed {
		logic [WIDTH-1:0] sum;
		logic cout;
	} result_word_t;

	// Link 0 leaves pre-computation, link LEVELS feeds post-computation
	stage_link_if #(.PAYLOAD_T(prefix_word_t)) link [0:LEVELS] (.clk(clk), .reset(reset));
	stage_link_if #(.PAYLOAD_T(result_word_t)) res_link (.clk(clk), .reset(reset));

	ling_precompute #(.WIDTH(WIDTH)) pre_i (
		.clk(clk),
		.reset(reset),
		.a(a),
		.b(b),
		.cin(cin),
		.in_req(in_req),
		.in_ack(in_ack),
		.out(link[0])
	);

	for (genvar l = 0; l < LEVELS; l++) begin : g_level
		knowles_level #(.WIDTH(WIDTH), .SPAN(level_span(l))) level_i (
			.clk(clk),
			.reset(reset),
			.up(link[l]),
			.dn(link[l+1])
		);
	end

	ling_postcompute #(.WIDTH(WIDTH)) post_i (
		.clk(clk),
		.reset(reset),
		.up(link[LEVELS]),
		.res(res_link)
	);

	assign res_link.ack = out_ack;
	assign out_req = res_link.req;
	assign sum = res_link.data.sum;
	assign cout = res_link.data.cout;

endmodule

// ==== tests/tb_clock_gen.sv ====
// Testbench clock source and synchronous reset sequence
module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 5,
	parameter int RELEASE_DELAY = 5
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

	// Reset held for a whole number of rising edges
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#(RELEASE_DELAY);
		reset = 1'b0;
	end

endmodule

// ==== tests/knowles_adder_tb.sv ====
// Table-driven testbench for the pipelined Ling Knowles adder
module knowles_adder_tb;
	import prefix_pkg::*;

	localparam int WIDTH = DEFAULT_WIDTH;
	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int DRIVE_DELAY = 10;
	// Pre-computation, five prefix levels and post-computation
	localparam int STAGES = 7;
	localparam int DIRECTED_ROWS = 10;
	localparam int RANDOM_ROWS = 40;
	localparam int ROWS = DIRECTED_ROWS + RANDOM_ROWS;
	localparam int STALL_CYCLES = 60;
	localparam int DRAIN_CYCLES = 10;
	localparam longint TIMEOUT =
		longint'(ROWS * 40 + RESET_CYCLES + STALL_CYCLES + DRAIN_CYCLES) * PERIOD;
	localparam logic [31:0] SEED = 32'h8df97fe7;

	typedef struct {
		logic [WIDTH-1:0] a;
		logic [WIDTH-1:0] b;
		logic cin;
		logic [WIDTH:0] total;
	} row_t;

	logic clk;
	logic reset;
	logic [WIDTH-1:0] a;
	logic [WIDTH-1:0] b;
	logic cin;
	logic in_req;
	logic in_ack;
	logic [WIDTH-1:0] sum;
	logic cout;
	logic out_req;
	logic out_ack;

	row_t rows [ROWS];
	int row_count;
	int in_handshakes;
	int out_handshakes;
	int error_count;
	logic [31:0] lcg_state;
	logic out_req_prev;

	tb_clock_gen #(
		.PERIOD(PERIOD),
		.RESET_CYCLES(RESET_CYCLES)
	) clock_i (
		.clk(clk),
		.reset(reset)
	);

	knowles_adder_top #(
		.WIDTH(DEFAULT_WIDTH)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.a(a),
		.b(b),
		.cin(cin),
		.in_req(in_req),
		.in_ack(in_ack),
		.sum(sum),
		.cout(cout),
		.out_req(out_req),
		.out_ack(out_ack)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] next_random();
		lcg_state = lcg_step(lcg_state);
		return lcg_state;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] expected);
		if (got !== expected) begin
			error_count++;
			abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h",
				name, got, expected));
		end
	endtask

	// Inputs change and outputs are sampled at the same point after the edge
	task automatic wait_cycle();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic add_row(input logic [WIDTH-1:0] a_v, input logic [WIDTH-1:0] b_v,
			input logic cin_v);
		rows[row_count].a = a_v;
		rows[row_count].b = b_v;
		rows[row_count].cin = cin_v;
		rows[row_count].total = {1'b0, a_v} + {1'b0, b_v} + {{WIDTH{1'b0}}, cin_v};
		row_count++;
	endtask

	task automatic build_table();
		logic [31:0] r;
		logic [WIDTH-1:0] a_v;
		logic [WIDTH-1:0] b_v;
		row_count = 0;
		add_row('0, '0, 1'b0);
		// Full ripple from bit 0 to cout
		add_row('1, '1, 1'b1);
		add_row(26'h2aaaaaa, 26'h1555555, 1'b0);
		add_row(26'h2aaaaaa, 26'h1555555, 1'b1);
		add_row(26'h2aaaaaa, 26'h2aaaaaa, 1'b0);
		// Generate at bit 0, propagated past the 16-bit span
		add_row(26'h1ffffff, 26'h0000001, 1'b0);
		add_row(26'h001ffff, 26'h0000001, 1'b0);
		add_row('1, '0, 1'b1);
		add_row('0, '1, 1'b1);
		add_row('0, '0, 1'b1);
		for (int n = 0; n < RANDOM_ROWS; n++) begin
			a_v = next_random() >> (32 - WIDTH);
			b_v = next_random() >> (32 - WIDTH);
			r = next_random();
			add_row(a_v, b_v, r[31]);
		end
	endtask

	task automatic check_reset();
		wait_cycle();
		while (reset) begin
			check_value("in_ack", in_ack, 1'b0);
			check_value("out_req", out_req, 1'b0);
			wait_cycle();
		end
		repeat (2) begin
			check_value("in_ack", in_ack, 1'b0);
			check_value("out_req", out_req, 1'b0);
			wait_cycle();
		end
	endtask

	task automatic produce();
		for (int r = 0; r < ROWS; r++) begin
			a = rows[r].a;
			b = rows[r].b;
			cin = rows[r].cin;
			in_req = 1'b1;
			do begin
				wait_cycle();
			end while (!in_ack);
			in_handshakes++;
			in_req = 1'b0;
			do begin
				wait_cycle();
			end while (in_ack);
		end
	endtask

	task automatic check_result(input int r);
		check_value($sformatf("sum[row %0d]", r), sum, rows[r].total[WIDTH-1:0]);
		check_value($sformatf("cout[row %0d]", r), cout, rows[r].total[WIDTH]);
	endtask

	task automatic consume();
		logic [31:0] r;
		int delay;
		// Hold the output side until every slot holds an item
		repeat (STALL_CYCLES) wait_cycle();
		check_value("out_req", out_req, 1'b1);
		check_value("in_handshakes", in_handshakes, STAGES);
		for (int n = 0; n < ROWS; n++) begin
			do begin
				wait_cycle();
			end while (!out_req);
			check_result(n);
			r = next_random();
			delay = r[31:16] % 6;
			repeat (delay) begin
				wait_cycle();
				check_value("out_req", out_req, 1'b1);
			end
			// Result must not move while out_req is high
			check_result(n);
			out_ack = 1'b1;
			do begin
				wait_cycle();
			end while (out_req);
			out_ack = 1'b0;
		end
	endtask

	task automatic check_drain();
		repeat (DRAIN_CYCLES) begin
			wait_cycle();
			check_value("out_req", out_req, 1'b0);
			check_value("in_ack", in_ack, 1'b0);
		end
		check_value("out_handshakes", out_handshakes, ROWS);
	endtask

	initial begin
		a = '0;
		b = '0;
		cin = 1'b0;
		in_req = 1'b0;
		out_ack = 1'b0;
		in_handshakes = 0;
		out_handshakes = 0;
		error_count = 0;
		lcg_state = SEED;
		build_table();
		check_reset();
		fork
			produce();
			consume();
		join
		check_drain();
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run($sformatf("%0d checks did not match", error_count));
		end
	end

	// Completed output handshakes, counted where out_req falls
	initial begin
		out_req_prev = 1'b0;
		forever begin
			wait_cycle();
			if (out_req_prev && !out_req) begin
				out_handshakes++;
			end
			out_req_prev = out_req;
		end
	end

	// Watchdog sized from row count, reset and the output stall
	initial begin
		#(TIMEOUT);
		abort_run($sformatf("Timeout: the run did not finish within %0d time units",
			TIMEOUT));
	end

endmodule

// ==== knowles_adder.f ====
hdl/prefix_pkg.sv
hdl/handshake_pkg.sv
hdl/stage_link_if.sv
hdl/hs_slot.sv
hdl/ling_precompute.sv
hdl/knowles_level.sv
hdl/ling_postcompute.sv
hdl/knowles_adder_top.sv
tests/tb_clock_gen.sv
tests/knowles_adder_tb.sv
